// File: hw/ahbl_pkg.sv
// Shared sizes, address map, enums and bus structs for the AHB-Lite fabric; import with ahbl_pkg::*
package ahbl_pkg;

	// ========================================================================
	// Fabric sizes
	// ========================================================================

	localparam int N_MASTERS = 2;
	localparam int N_SLAVES  = 3;
	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;

	// Index widths derived from the sizes above
	localparam int W_SEL  = 2;
	localparam int W_MIDX = $clog2(N_MASTERS);

	// Memory behind each slave port, word index is haddr[7:2]
	localparam int SRAM_WORDS = 64;
	localparam int W_WIDX     = $clog2(SRAM_WORDS);

	// ========================================================================
	// Address map
	// ========================================================================

	// Slave j sits where haddr[31:28] == j, anything above N_SLAVES-1 is unmapped
	localparam int SLAVE_BASE_BIT = 28;
	localparam int W_FIELD        = 4;

	// ========================================================================
	// Bus encodings and bundles
	// ========================================================================

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		BUSY   = 2'd1,
		NONSEQ = 2'd2,
		SEQ    = 2'd3
	} htrans_e;

	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Address phase
	typedef struct packed {
		htrans_e           htrans;
		logic              hwrite;
		logic [W_ADDR-1:0] haddr;
	} ahbl_req_t;

	// Data phase response
	typedef struct packed {
		logic              hready_resp;
		hresp_e            hresp;
		logic [W_DATA-1:0] hrdata;
	} ahbl_resp_t;

	localparam ahbl_req_t  REQ_IDLE  = '{htrans: IDLE, hwrite: 1'b0, haddr: '0};
	localparam ahbl_resp_t RESP_IDLE = '{hready_resp: 1'b1, hresp: OKAY, hrdata: '0};

endpackage

// File: hw/ahbl_splitter.sv
// Per-master address decoder, steering each transfer to one slave port and answering holes with ERROR
`timescale 1ns/1ps

module ahbl_splitter import ahbl_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  ahbl_req_t         req_m,
	input  logic              hready,
	input  logic [W_DATA-1:0] hwdata_m,
	output ahbl_resp_t        resp_m,
	output ahbl_req_t         req_s [N_SLAVES],
	output logic [W_DATA-1:0] hwdata_s [N_SLAVES],
	input  ahbl_resp_t        resp_s [N_SLAVES]
);

	typedef enum logic [1:0] {
		ERR_IDLE,
		ERR_FIRST,
		ERR_SECOND
	} err_state_e;

	logic [W_FIELD-1:0]  slv_field;
	logic [N_SLAVES-1:0] sel;
	logic                mapped;
	logic                accept;
	logic                dp_valid;
	logic [W_SEL-1:0]    dp_owner;
	err_state_e          err_state;

	// ========================================================================
	// Address phase decode
	// ========================================================================

	assign slv_field = req_m.haddr[SLAVE_BASE_BIT +: W_FIELD];
	assign mapped    = slv_field < W_FIELD'(N_SLAVES);
	assign accept    = hready && (req_m.htrans == NONSEQ);

	// Only the selected slave sees a live transfer
	always_comb begin
		for (int j = 0; j < N_SLAVES; j++) begin
			sel[j]   = (slv_field == W_FIELD'(j));
			req_s[j] = req_m;
			if (!sel[j]) begin
				req_s[j].htrans = IDLE;
			end
		end
	end

	// ========================================================================
	// Data phase tracking
	// ========================================================================

	// First ERROR cycle always stalls, so it advances without hready
	always_ff @(posedge clk) begin
		if (rst) begin
			dp_valid  <= 1'b0;
			dp_owner  <= '0;
			err_state <= ERR_IDLE;
		end else if (err_state == ERR_FIRST) begin
			err_state <= ERR_SECOND;
		end else if (hready) begin
			dp_valid  <= accept && mapped;
			dp_owner  <= slv_field[W_SEL-1:0];
			err_state <= (accept && !mapped) ? ERR_FIRST : ERR_IDLE;
		end
	end

	// Two-cycle ERROR for holes, otherwise the owning slave's response
	always_comb begin
		resp_m = RESP_IDLE;
		case (err_state)
			ERR_FIRST: begin
				resp_m.hready_resp = 1'b0;
				resp_m.hresp       = ERROR;
			end
			ERR_SECOND: begin
				resp_m.hresp = ERROR;
			end
			default: begin
				if (dp_valid) begin
					resp_m = resp_s[dp_owner];
				end
			end
		endcase
	end

	// Write data only toggles toward the slave that owns the data phase
	always_comb begin
		for (int j = 0; j < N_SLAVES; j++) begin
			hwdata_s[j] = (dp_valid && dp_owner == W_SEL'(j)) ? hwdata_m : '0;
		end
	end

endmodule

// File: hw/ahbl_arbiter.sv
// Per-slave round-robin arbiter; buffers losing address phases and stalls those masters
`timescale 1ns/1ps

module ahbl_arbiter import ahbl_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  ahbl_req_t         req_m [N_MASTERS],
	input  logic              hready_m [N_MASTERS],
	input  logic [W_DATA-1:0] hwdata_m [N_MASTERS],
	output ahbl_resp_t        resp_m [N_MASTERS],
	output ahbl_req_t         req_s,
	output logic              hready_s,
	output logic [W_DATA-1:0] hwdata_s,
	input  ahbl_resp_t        resp_s
);

	logic [N_MASTERS-1:0] live;
	logic [N_MASTERS-1:0] cand;
	logic [N_MASTERS-1:0] pend;
	ahbl_req_t            pend_req [N_MASTERS];
	ahbl_req_t            cand_req [N_MASTERS];
	logic                 grant_valid;
	logic [W_MIDX-1:0]    grant;
	logic [W_MIDX-1:0]    rr_ptr;
	logic                 dp_valid;
	logic [W_MIDX-1:0]    dp_owner;

	// Single slave on this port, so its ready is the bus ready
	assign hready_s = resp_s.hready_resp;

	// ========================================================================
	// Request selection
	// ========================================================================

	// A stalled master has hready low, so live and pend never overlap
	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			live[i]     = hready_m[i] && (req_m[i].htrans == NONSEQ);
			cand[i]     = live[i] || pend[i];
			cand_req[i] = pend[i] ? pend_req[i] : req_m[i];
		end
	end

	// Walk down from the far end so the master nearest rr_ptr wins
	always_comb begin
		int idx;
		grant_valid = 1'b0;
		grant       = '0;
		for (int k = N_MASTERS - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % N_MASTERS;
			if (cand[idx] && hready_s) begin
				grant_valid = 1'b1;
				grant       = W_MIDX'(idx);
			end
		end
	end

	assign req_s = grant_valid ? cand_req[grant] : REQ_IDLE;

	// ========================================================================
	// Arbitration state
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pend     <= '0;
			rr_ptr   <= '0;
			dp_valid <= 1'b0;
			dp_owner <= '0;
		end else begin
			for (int i = 0; i < N_MASTERS; i++) begin
				if (grant_valid && grant == W_MIDX'(i)) begin
					pend[i] <= 1'b0;
				end else if (live[i]) begin
					pend[i] <= 1'b1;
				end
			end
			if (hready_s) begin
				dp_valid <= grant_valid;
				if (grant_valid) begin
					dp_owner <= grant;
				end
			end
			if (grant_valid) begin
				rr_ptr <= (int'(grant) == N_MASTERS - 1) ? '0 : grant + 1'b1;
			end
		end
	end

	// Losing address phase is captured once, the master then sits stalled
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_MASTERS; i++) begin
			if (live[i] && !(grant_valid && grant == W_MIDX'(i))) begin
				pend_req[i] <= req_m[i];
			end
		end
	end

	// ========================================================================
	// Data phase routing
	// ========================================================================

	assign hwdata_s = dp_valid ? hwdata_m[dp_owner] : '0;

	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			if (dp_valid && dp_owner == W_MIDX'(i)) begin
				resp_m[i] = resp_s;
			end else begin
				resp_m[i]             = RESP_IDLE;
				resp_m[i].hready_resp = !pend[i];
			end
		end
	end

endmodule

// File: hw/ahbl_crossbar.sv
// Master-by-slave matrix of splitters and arbiters; masters enter here, slave ports leave toward memories
`timescale 1ns/1ps

module ahbl_crossbar import ahbl_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  ahbl_req_t         req_m [N_MASTERS],
	input  logic [W_DATA-1:0] hwdata_m [N_MASTERS],
	output ahbl_resp_t        resp_m [N_MASTERS],
	output ahbl_req_t         req_s [N_SLAVES],
	output logic              hready_s [N_SLAVES],
	output logic [W_DATA-1:0] hwdata_s [N_SLAVES],
	input  ahbl_resp_t        resp_s [N_SLAVES]
);

	// Requests and write data are indexed [slave][master], responses [master][slave]
	ahbl_req_t         xbar_req   [N_SLAVES][N_MASTERS];
	logic [W_DATA-1:0] xbar_wdata [N_SLAVES][N_MASTERS];
	ahbl_resp_t        xbar_resp  [N_MASTERS][N_SLAVES];
	logic              m_hready   [N_MASTERS];

	// ========================================================================
	// Splitters, one per master
	// ========================================================================

	for (genvar i = 0; i < N_MASTERS; i++) begin : g_split
		ahbl_req_t         split_req   [N_SLAVES];
		logic [W_DATA-1:0] split_wdata [N_SLAVES];

		assign m_hready[i] = resp_m[i].hready_resp;

		for (genvar j = 0; j < N_SLAVES; j++) begin : g_conn
			assign xbar_req[j][i]   = split_req[j];
			assign xbar_wdata[j][i] = split_wdata[j];
		end

		// Master hready is its own hready_resp
		ahbl_splitter split_i (
			.clk      (clk),
			.rst      (rst),
			.req_m    (req_m[i]),
			.hready   (resp_m[i].hready_resp),
			.hwdata_m (hwdata_m[i]),
			.resp_m   (resp_m[i]),
			.req_s    (split_req),
			.hwdata_s (split_wdata),
			.resp_s   (xbar_resp[i])
		);
	end

	// ========================================================================
	// Arbiters, one per slave
	// ========================================================================

	for (genvar j = 0; j < N_SLAVES; j++) begin : g_arb
		ahbl_resp_t arb_resp [N_MASTERS];

		for (genvar i = 0; i < N_MASTERS; i++) begin : g_conn
			assign xbar_resp[i][j] = arb_resp[i];
		end

		ahbl_arbiter arb_i (
			.clk      (clk),
			.rst      (rst),
			.req_m    (xbar_req[j]),
			.hready_m (m_hready),
			.hwdata_m (xbar_wdata[j]),
			.resp_m   (arb_resp),
			.req_s    (req_s[j]),
			.hready_s (hready_s[j]),
			.hwdata_s (hwdata_s[j]),
			.resp_s   (resp_s[j])
		);
	end

endmodule

// File: hw/ahbl_sram.sv
// Zero-wait-state word memory serving as the AHB-Lite slave behind one arbiter port
`timescale 1ns/1ps

module ahbl_sram import ahbl_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  ahbl_req_t         req,
	input  logic              hready,
	input  logic [W_DATA-1:0] hwdata,
	output ahbl_resp_t        resp
);

	logic [W_DATA-1:0]     mem [SRAM_WORDS];
	logic [SRAM_WORDS-1:0] written;
	logic [W_WIDX-1:0]     dp_idx;
	logic                  wr_en;
	logic                  accept;

	assign accept = hready && (req.htrans == NONSEQ);

	// Write enable and per-word written flags
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en   <= 1'b0;
			written <= '0;
		end else begin
			if (hready) begin
				wr_en <= accept && req.hwrite;
			end
			if (wr_en && hready) begin
				written[dp_idx] <= 1'b1;
			end
		end
	end

	// Word index captured at the address phase, data lands at the end of the data phase
	always_ff @(posedge clk) begin
		if (accept) begin
			dp_idx <= req.haddr[2 +: W_WIDX];
		end
		if (wr_en && hready) begin
			mem[dp_idx] <= hwdata;
		end
	end

	// Never stalls, never errors; unwritten words read as zero
	always_comb begin
		resp        = RESP_IDLE;
		resp.hrdata = written[dp_idx] ? mem[dp_idx] : '0;
	end

endmodule

// File: hw/ahbl_fabric_top.sv
// Fabric top level with the crossbar and one SRAM per slave port, exposing only master ports
`timescale 1ns/1ps

module ahbl_fabric_top import ahbl_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  ahbl_req_t         req [N_MASTERS],
	input  logic [W_DATA-1:0] hwdata [N_MASTERS],
	output ahbl_resp_t        resp [N_MASTERS]
);

	ahbl_req_t         s_req    [N_SLAVES];
	logic              s_hready [N_SLAVES];
	logic [W_DATA-1:0] s_wdata  [N_SLAVES];
	ahbl_resp_t        s_resp   [N_SLAVES];

	ahbl_crossbar xbar_i (
		.clk      (clk),
		.rst      (rst),
		.req_m    (req),
		.hwdata_m (hwdata),
		.resp_m   (resp),
		.req_s    (s_req),
		.hready_s (s_hready),
		.hwdata_s (s_wdata),
		.resp_s   (s_resp)
	);

	for (genvar j = 0; j < N_SLAVES; j++) begin : g_sram
		ahbl_sram sram_i (
			.clk    (clk),
			.rst    (rst),
			.req    (s_req[j]),
			.hready (s_hready[j]),
			.hwdata (s_wdata[j]),
			.resp   (s_resp[j])
		);
	end

endmodule

// File: testbench/ahbl_fabric_chk.sv
// Protocol assertions on the fabric master ports, attached to ahbl_fabric_top with bind
`timescale 1ns/1ps

module ahbl_fabric_chk import ahbl_pkg::*; (
	input logic       clk,
	input logic       rst,
	input ahbl_req_t  req [N_MASTERS],
	input ahbl_resp_t resp [N_MASTERS]
);

	for (genvar i = 0; i < N_MASTERS; i++) begin : g_port
		// Stalling ERROR cycle is always followed by the completing one
		err_two_cycle: assert property (@(posedge clk) disable iff (rst)
			(resp[i].hresp == ERROR && !resp[i].hready_resp)
			|=> (resp[i].hresp == ERROR && resp[i].hready_resp))
			else $error("Master %0d ERROR response did not complete in its second cycle", i);

		// Master holds its request while stalled
		req_hold: assert property (@(posedge clk) disable iff (rst)
			!resp[i].hready_resp |=> $stable(req[i]))
			else $error("Master %0d changed its request while hready_resp was low", i);

		// Fabric comes out of reset ready and OKAY
		reset_ready: assert property (@(posedge clk)
			$fell(rst) |-> (resp[i].hready_resp && resp[i].hresp == OKAY))
			else $error("Master %0d not ready with OKAY after reset", i);
	end

endmodule

bind ahbl_fabric_top ahbl_fabric_chk chk_i (
	.clk  (clk),
	.rst  (rst),
	.req  (req),
	.resp (resp)
);

// File: testbench/tb_ahbl_fabric.sv
// Testbench for the AHB-Lite fabric; two random masters checked against a memory model
`timescale 1ns/1ps

module tb_ahbl_fabric import ahbl_pkg::*; ();

	localparam int N_XFERS    = 300;
	localparam int MAX_CYCLES = N_XFERS * 6 + 100;

	typedef struct packed {
		logic [1:0]         gap;
		logic               write;
		logic [W_FIELD-1:0] field;
		logic [W_WIDX-1:0]  word;
		logic [W_DATA-1:0]  data;
	} xfer_t;

	logic              clk = 1'b0;
	logic              rst;
	ahbl_req_t         req [N_MASTERS];
	logic [W_DATA-1:0] hwdata [N_MASTERS];
	ahbl_resp_t        resp [N_MASTERS];

	logic [31:0]       lfsr_state;
	xfer_t             xfers [N_MASTERS][N_XFERS];
	logic [W_DATA-1:0] model [N_SLAVES][SRAM_WORDS];
	int                cycles;
	int                err_data;
	int                err_resp;
	int                err_lat;

	ahbl_fabric_top dut_i (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.hwdata (hwdata),
		.resp   (resp)
	);

	always #10 clk = ~clk;

	// ========================================================================
	// Random source
	// ========================================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v          = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic xfer_t make_xfer(input logic write, input int field, input int word,
			input logic [W_DATA-1:0] data);
		xfer_t x;
		x.gap   = '0;
		x.write = write;
		x.field = W_FIELD'(field);
		x.word  = W_WIDX'(word);
		x.data  = data;
		return x;
	endfunction

	function automatic logic [W_ADDR-1:0] make_addr(input xfer_t x);
		return (W_ADDR'(x.field) << SLAVE_BASE_BIT) | (W_ADDR'(x.word) << 2);
	endfunction

	// Slave pick 3 stands for any hole from 3 to 15
	task automatic gen_xfers();
		logic [1:0] pick;
		for (int k = 0; k < N_XFERS; k++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				xfers[m][k].gap   = 2'(take_bits(2));
				xfers[m][k].write = 1'(take_bits(1));
				pick              = 2'(take_bits(2));
				if (pick == 2'd3) begin
					xfers[m][k].field = W_FIELD'(3 + (take_bits(4) % 13));
				end else begin
					xfers[m][k].field = W_FIELD'(pick);
				end
				// Each master keeps to its own half of every SRAM
				xfers[m][k].word               = W_WIDX'(take_bits(W_WIDX - 1));
				xfers[m][k].word[W_WIDX - 1]   = m[0];
				xfers[m][k].data               = W_DATA'(take_bits(W_DATA));
			end
		end
	endtask

	// ========================================================================
	// Master transfer and checks
	// ========================================================================

	task automatic do_xfer(input int m, input xfer_t x, input int max_lat);
		int                lat;
		logic              mapped;
		logic [W_SEL-1:0]  sidx;
		logic [W_DATA-1:0] exp_data;
		mapped = x.field < W_FIELD'(N_SLAVES);
		sidx   = x.field[W_SEL-1:0];
		lat    = 0;
		repeat (int'(x.gap)) @(posedge clk);
		req[m] <= '{htrans: NONSEQ, hwrite: x.write, haddr: make_addr(x)};
		do begin
			@(posedge clk);
		end while (!resp[m].hready_resp);
		// Accepted, now in the data phase
		req[m]    <= REQ_IDLE;
		hwdata[m] <= x.data;
		do begin
			@(posedge clk);
			lat++;
		end while (!resp[m].hready_resp);
		if (mapped) begin
			assert (resp[m].hresp == OKAY) else begin
				$display("Fail at %0t: resp[%0d].hresp = %0d, expected %0d",
					$time, m, resp[m].hresp, OKAY);
				err_resp++;
			end
			if (x.write) begin
				model[sidx][x.word] = x.data;
			end else begin
				exp_data = model[sidx][x.word];
				assert (resp[m].hrdata == exp_data) else begin
					$display("Fail at %0t: resp[%0d].hrdata = %h, expected %h",
						$time, m, resp[m].hrdata, exp_data);
					err_data++;
				end
			end
			assert (lat <= max_lat) else begin
				$display("Master %0d data phase ending at %0t took %0d cycles, more than %0d",
					m, $time, lat, max_lat);
				err_lat++;
			end
		end else begin
			assert (resp[m].hresp == ERROR) else begin
				$display("Fail at %0t: resp[%0d].hresp = %0d, expected %0d",
					$time, m, resp[m].hresp, ERROR);
				err_resp++;
			end
			assert (lat == 2) else begin
				$display("Master %0d unmapped access ending at %0t took %0d cycles, not 2",
					m, $time, lat);
				err_lat++;
			end
		end
	endtask

	task automatic run_master(input int m);
		for (int k = 0; k < N_XFERS; k++) begin
			do_xfer(m, xfers[m][k], N_MASTERS);
		end
	endtask

	task automatic report_counts();
		$display("Error counts: data %0d, response %0d, latency %0d", err_data, err_resp, err_lat);
	endtask

	// ========================================================================
	// Run control
	// ========================================================================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles with transfers still outstanding", cycles);
			report_counts();
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic [W_DATA-1:0] d0;
		logic [W_DATA-1:0] d1;
		rst        = 1'b1;
		lfsr_state = 32'd69;
		cycles     = 0;
		err_data   = 0;
		err_resp   = 0;
		err_lat    = 0;
		for (int i = 0; i < N_MASTERS; i++) begin
			req[i]    = REQ_IDLE;
			hwdata[i] = '0;
		end
		for (int j = 0; j < N_SLAVES; j++) begin
			for (int w = 0; w < SRAM_WORDS; w++) begin
				model[j][w] = '0;
			end
		end
		gen_xfers();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Master 0 alone, every access must finish one edge after acceptance
		for (int j = 0; j < N_SLAVES; j++) begin
			d0 = W_DATA'(take_bits(W_DATA));
			do_xfer(0, make_xfer(1'b1, j, 5, d0), 1);
			do_xfer(0, make_xfer(1'b0, j, 5, '0), 1);
		end
		do_xfer(0, make_xfer(1'b0, 9, 1, '0), 1);

		// Both masters hit slave 2 on the same edge
		d0 = W_DATA'(take_bits(W_DATA));
		d1 = W_DATA'(take_bits(W_DATA));
		fork
			do_xfer(0, make_xfer(1'b1, 2, 3, d0), N_MASTERS);
			do_xfer(1, make_xfer(1'b1, 2, 35, d1), N_MASTERS);
		join
		fork
			do_xfer(0, make_xfer(1'b0, 2, 3, '0), N_MASTERS);
			do_xfer(1, make_xfer(1'b0, 2, 35, '0), N_MASTERS);
		join

		fork
			run_master(0);
			run_master(1);
		join
		repeat (2) @(posedge clk);

		report_counts();
		if (err_data + err_resp + err_lat == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
hw/ahbl_pkg.sv
hw/ahbl_splitter.sv
hw/ahbl_arbiter.sv
hw/ahbl_crossbar.sv
hw/ahbl_sram.sv
hw/ahbl_fabric_top.sv
testbench/ahbl_fabric_chk.sv
testbench/tb_ahbl_fabric.sv

// File: Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module tb_ahbl_fabric -f filelist.f
	@out="$$(./obj_dir/Vtb_ahbl_fabric)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_ahbl_fabric -f filelist.f

clean:
	rm -rf obj_dir
